// File: src/dtm_pkg.sv
package dtm_pkg;

  localparam int IR_WIDTH = 5;

  // dmi address width, also reported in dtmcs
  localparam int DTMCS_ABITS = 7;
  localparam logic [3:0] DTMCS_VERSION = 4'd1;

  localparam logic [31:0] IDCODE_VALUE = 32'h10E3_1913;
  localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 5'b00101;

  // version 2, authenticated
  localparam logic [31:0] DMSTATUS_VALUE = 32'h0000_0C82;

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_e;

  // instruction 0 is not listed and falls back to bypass
  typedef enum logic [IR_WIDTH-1:0] {
    IDCODE = 5'h01,
    DTMCS  = 5'h10,
    DMI    = 5'h11,
    BYPASS = 5'h1F
  } tap_ins_e;

  typedef enum logic [DTMCS_ABITS-1:0] {
    DATA0     = 7'h04,
    DATA1     = 7'h05,
    DMCONTROL = 7'h10,
    DMSTATUS  = 7'h11
  } dm_addr_e;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dmi_op_e;

  typedef struct packed {
    dm_addr_e    addr;
    logic [31:0] data;
    dmi_op_e     op;
  } dmi_req_t;

endpackage

// File: src/dtm_scan_if.sv
`timescale 1ns/100ps

interface dtm_scan_if;

  logic tdi;
  // state decodes from the tap fsm
  logic capture_dr;
  logic shift_dr;
  logic update_dr;
  logic test_logic_reset;

  modport ctrl (
    output tdi,
    output capture_dr,
    output shift_dr,
    output update_dr,
    output test_logic_reset
  );

  modport dreg (
    input tdi,
    input capture_dr,
    input shift_dr,
    input update_dr,
    input test_logic_reset
  );

endinterface

// File: src/dmi_if.sv
`timescale 1ns/100ps

interface dmi_if;

  logic               wr;
  logic               rd;
  dtm_pkg::dm_addr_e  addr;
  logic [31:0]        wdata;
  // combinational from addr
  logic [31:0]        rdata;

  modport host (
    output wr,
    output rd,
    output addr,
    output wdata,
    input  rdata
  );

  modport target (
    input  wr,
    input  rd,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: src/tap_controller.sv
`timescale 1ns/100ps

module tap_controller (
  input  logic        tck_i,
  input  logic        trstn_i,
  input  logic        tms_i,
  input  logic        tdi_i,
  dtm_scan_if.ctrl    scan_o,
  output logic        idcode_sel_o,
  output logic        dtmcs_sel_o,
  output logic        dmi_sel_o,
  output logic        bypass_sel_o,
  input  logic        idcode_tdo_i,
  input  logic        dtmcs_tdo_i,
  input  logic        dmi_tdo_i,
  input  logic        bypass_tdo_i,
  output logic        tdo_o
);

  dtm_pkg::tap_state_e        state_q;
  dtm_pkg::tap_state_e        state_d;
  logic [dtm_pkg::IR_WIDTH-1:0] ir_shift_q;
  dtm_pkg::tap_ins_e          ir_q;
  logic                       capture_ir;
  logic                       shift_ir;
  logic                       update_ir;
  logic                       dr_tdo;

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      state_q <= dtm_pkg::TEST_LOGIC_RESET;
    else
      state_q <= state_d;
  end

  // standard 1149.1 transitions
  always_comb
  begin
    case (state_q)
      dtm_pkg::TEST_LOGIC_RESET:
        state_d = tms_i ? dtm_pkg::TEST_LOGIC_RESET : dtm_pkg::RUN_TEST_IDLE;
      dtm_pkg::RUN_TEST_IDLE:
        state_d = tms_i ? dtm_pkg::SELECT_DR_SCAN : dtm_pkg::RUN_TEST_IDLE;
      dtm_pkg::SELECT_DR_SCAN:
        state_d = tms_i ? dtm_pkg::SELECT_IR_SCAN : dtm_pkg::CAPTURE_DR;
      dtm_pkg::CAPTURE_DR: state_d = tms_i ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
      dtm_pkg::SHIFT_DR:   state_d = tms_i ? dtm_pkg::EXIT1_DR : dtm_pkg::SHIFT_DR;
      dtm_pkg::EXIT1_DR:   state_d = tms_i ? dtm_pkg::UPDATE_DR : dtm_pkg::PAUSE_DR;
      dtm_pkg::PAUSE_DR:   state_d = tms_i ? dtm_pkg::EXIT2_DR : dtm_pkg::PAUSE_DR;
      dtm_pkg::EXIT2_DR:   state_d = tms_i ? dtm_pkg::UPDATE_DR : dtm_pkg::SHIFT_DR;
      dtm_pkg::UPDATE_DR:
        state_d = tms_i ? dtm_pkg::SELECT_DR_SCAN : dtm_pkg::RUN_TEST_IDLE;
      dtm_pkg::SELECT_IR_SCAN:
        state_d = tms_i ? dtm_pkg::TEST_LOGIC_RESET : dtm_pkg::CAPTURE_IR;
      dtm_pkg::CAPTURE_IR: state_d = tms_i ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
      dtm_pkg::SHIFT_IR:   state_d = tms_i ? dtm_pkg::EXIT1_IR : dtm_pkg::SHIFT_IR;
      dtm_pkg::EXIT1_IR:   state_d = tms_i ? dtm_pkg::UPDATE_IR : dtm_pkg::PAUSE_IR;
      dtm_pkg::PAUSE_IR:   state_d = tms_i ? dtm_pkg::EXIT2_IR : dtm_pkg::PAUSE_IR;
      dtm_pkg::EXIT2_IR:   state_d = tms_i ? dtm_pkg::UPDATE_IR : dtm_pkg::SHIFT_IR;
      dtm_pkg::UPDATE_IR:
        state_d = tms_i ? dtm_pkg::SELECT_DR_SCAN : dtm_pkg::RUN_TEST_IDLE;
      default:             state_d = dtm_pkg::TEST_LOGIC_RESET;
    endcase
  end

  assign scan_o.tdi              = tdi_i;
  assign scan_o.capture_dr       = (state_q == dtm_pkg::CAPTURE_DR);
  assign scan_o.shift_dr         = (state_q == dtm_pkg::SHIFT_DR);
  assign scan_o.update_dr        = (state_q == dtm_pkg::UPDATE_DR);
  assign scan_o.test_logic_reset = (state_q == dtm_pkg::TEST_LOGIC_RESET);
  assign capture_ir = (state_q == dtm_pkg::CAPTURE_IR);
  assign shift_ir   = (state_q == dtm_pkg::SHIFT_IR);
  assign update_ir  = (state_q == dtm_pkg::UPDATE_IR);

  // ir shift stage, lsb first
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      ir_shift_q <= dtm_pkg::IR_CAPTURE;
    else if (capture_ir)
      ir_shift_q <= dtm_pkg::IR_CAPTURE;
    else if (shift_ir)
      ir_shift_q <= {tdi_i, ir_shift_q[dtm_pkg::IR_WIDTH-1:1]};
  end

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      ir_q <= dtm_pkg::IDCODE;
    else if (scan_o.test_logic_reset)
      ir_q <= dtm_pkg::IDCODE;
    else if (update_ir)
      ir_q <= dtm_pkg::tap_ins_e'(ir_shift_q);
  end

  // unknown codes, 0 included, select bypass
  assign idcode_sel_o = (ir_q == dtm_pkg::IDCODE);
  assign dtmcs_sel_o  = (ir_q == dtm_pkg::DTMCS);
  assign dmi_sel_o    = (ir_q == dtm_pkg::DMI);
  assign bypass_sel_o = !(idcode_sel_o || dtmcs_sel_o || dmi_sel_o);

  assign dr_tdo = idcode_sel_o ? idcode_tdo_i :
                  dtmcs_sel_o  ? dtmcs_tdo_i  :
                  dmi_sel_o    ? dmi_tdo_i    : bypass_tdo_i;

  always_ff @(negedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      tdo_o <= 1'b0;
    else if (shift_ir)
      tdo_o <= ir_shift_q[0];
    else
      tdo_o <= dr_tdo;
  end

  a_sel_onehot: assert property (@(posedge tck_i) disable iff (!trstn_i)
    $onehot({idcode_sel_o, dtmcs_sel_o, dmi_sel_o, bypass_sel_o}));

  // tms high for five edges reaches reset from anywhere
  a_tms_reset: assert property (@(posedge tck_i) disable iff (!trstn_i)
    tms_i [*5] |=> state_q == dtm_pkg::TEST_LOGIC_RESET);

endmodule

// File: src/scan_dr.sv
`timescale 1ns/100ps

module scan_dr #(
  parameter type payload_t = logic [31:0]
) (
  input  logic      tck_i,
  input  logic      trstn_i,
  dtm_scan_if.dreg  scan_i,
  input  logic      sel_i,
  input  payload_t  capture_i,
  output logic      tdo_o
);

  payload_t dr_q;
  payload_t dr_shifted;

  // tdi enters at the msb
  if ($bits(payload_t) > 1)
  begin : g_wide
    assign dr_shifted = payload_t'({scan_i.tdi, dr_q[$bits(payload_t)-1:1]});
  end
  else
  begin : g_bit
    assign dr_shifted = payload_t'(scan_i.tdi);
  end

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      dr_q <= capture_i;
    else if (scan_i.test_logic_reset)
      dr_q <= capture_i;
    else if (sel_i && scan_i.capture_dr)
      dr_q <= capture_i;
    else if (sel_i && scan_i.shift_dr)
      dr_q <= dr_shifted;
  end

  assign tdo_o = dr_q[0];

endmodule

// File: src/dmi_bridge.sv
`timescale 1ns/100ps

module dmi_bridge (
  input  logic      tck_i,
  input  logic      trstn_i,
  dtm_scan_if.dreg  scan_i,
  input  logic      sel_i,
  output logic      tdo_o,
  dmi_if.host       dmi_o
);

  dtm_pkg::dmi_req_t req_q;
  dtm_pkg::dm_addr_e rd_addr_q;
  logic              update;

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      req_q <= '0;
    else if (scan_i.test_logic_reset)
      req_q <= '0;
    else if (sel_i && scan_i.capture_dr)
    begin
      // address stays, op 0 reports success
      req_q.data <= dmi_o.rdata;
      req_q.op   <= dtm_pkg::NOP;
    end
    else if (sel_i && scan_i.shift_dr)
      req_q <= dtm_pkg::dmi_req_t'({scan_i.tdi, req_q[$bits(dtm_pkg::dmi_req_t)-1:1]});
  end

  assign tdo_o  = req_q[0];
  assign update = scan_i.update_dr && sel_i;

  assign dmi_o.wr    = update && (req_q.op == dtm_pkg::WRITE);
  assign dmi_o.rd    = update && (req_q.op == dtm_pkg::READ);
  assign dmi_o.wdata = req_q.data;

  // read address held so the next capture sees its data
  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
      rd_addr_q <= dtm_pkg::DATA0;
    else if (dmi_o.rd)
      rd_addr_q <= req_q.addr;
  end

  assign dmi_o.addr = update ? req_q.addr : rd_addr_q;

  a_wr_rd_excl: assert property (@(posedge tck_i) disable iff (!trstn_i)
    !(dmi_o.wr && dmi_o.rd));

  a_strobe_pulse: assert property (@(posedge tck_i) disable iff (!trstn_i)
    (dmi_o.wr || dmi_o.rd) |=> !(dmi_o.wr || dmi_o.rd));

endmodule

// File: src/dm_regfile.sv
`timescale 1ns/100ps

module dm_regfile (
  input  logic   tck_i,
  input  logic   trstn_i,
  dmi_if.target  dmi_i,
  output logic   dmactive_o,
  output logic   ndmreset_o
);

  logic [31:0] data0_q;
  logic [31:0] data1_q;
  logic        dmactive_q;
  logic        ndmreset_q;

  always_ff @(posedge tck_i or negedge trstn_i)
  begin
    if (!trstn_i)
    begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
    end
    else if (dmi_i.wr && (dmi_i.addr == dtm_pkg::DMCONTROL))
    begin
      dmactive_q <= dmi_i.wdata[0];
      ndmreset_q <= dmi_i.wdata[1];
    end
  end

  // data regs only writable while the dm is active
  always_ff @(posedge tck_i)
  begin
    if (dmi_i.wr && dmactive_q)
    begin
      if (dmi_i.addr == dtm_pkg::DATA0)
        data0_q <= dmi_i.wdata;
      if (dmi_i.addr == dtm_pkg::DATA1)
        data1_q <= dmi_i.wdata;
    end
  end

  always_comb
  begin
    case (dmi_i.addr)
      dtm_pkg::DATA0:     dmi_i.rdata = data0_q;
      dtm_pkg::DATA1:     dmi_i.rdata = data1_q;
      dtm_pkg::DMCONTROL: dmi_i.rdata = {30'd0, ndmreset_q, dmactive_q};
      dtm_pkg::DMSTATUS:  dmi_i.rdata = dtm_pkg::DMSTATUS_VALUE;
      default:            dmi_i.rdata = '0;
    endcase
  end

  assign dmactive_o = dmactive_q;
  assign ndmreset_o = ndmreset_q;

  // bridge must keep the read address on the bus after the strobe
  a_rd_addr_held: assert property (@(posedge tck_i) disable iff (!trstn_i)
    dmi_i.rd |=> $stable(dmi_i.addr));

endmodule

// File: src/dtm_top.sv
`timescale 1ns/100ps

module dtm_top (
  input  logic tck_i,
  input  logic trstn_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o,
  output logic dmactive_o,
  output logic ndmreset_o
);

  logic idcode_sel;
  logic dtmcs_sel;
  logic dmi_sel;
  logic bypass_sel;
  logic idcode_tdo;
  logic dtmcs_tdo;
  logic dmi_tdo;
  logic bypass_tdo;

  dtm_scan_if u_scan_if ();
  dmi_if      u_dmi_if ();

  tap_controller u_tap_controller (
    .tck_i        (tck_i),
    .trstn_i      (trstn_i),
    .tms_i        (tms_i),
    .tdi_i        (tdi_i),
    .scan_o       (u_scan_if.ctrl),
    .idcode_sel_o (idcode_sel),
    .dtmcs_sel_o  (dtmcs_sel),
    .dmi_sel_o    (dmi_sel),
    .bypass_sel_o (bypass_sel),
    .idcode_tdo_i (idcode_tdo),
    .dtmcs_tdo_i  (dtmcs_tdo),
    .dmi_tdo_i    (dmi_tdo),
    .bypass_tdo_i (bypass_tdo),
    .tdo_o        (tdo_o)
  );

  scan_dr #(.payload_t(logic [31:0])) u_idcode_dr (
    .tck_i     (tck_i),
    .trstn_i   (trstn_i),
    .scan_i    (u_scan_if.dreg),
    .sel_i     (idcode_sel),
    .capture_i (dtm_pkg::IDCODE_VALUE),
    .tdo_o     (idcode_tdo)
  );

  // abits in [9:4], version in [3:0]
  scan_dr #(.payload_t(logic [31:0])) u_dtmcs_dr (
    .tck_i     (tck_i),
    .trstn_i   (trstn_i),
    .scan_i    (u_scan_if.dreg),
    .sel_i     (dtmcs_sel),
    .capture_i ({22'd0, 6'(dtm_pkg::DTMCS_ABITS), dtm_pkg::DTMCS_VERSION}),
    .tdo_o     (dtmcs_tdo)
  );

  scan_dr #(.payload_t(logic [0:0])) u_bypass_dr (
    .tck_i     (tck_i),
    .trstn_i   (trstn_i),
    .scan_i    (u_scan_if.dreg),
    .sel_i     (bypass_sel),
    .capture_i (1'b0),
    .tdo_o     (bypass_tdo)
  );

  dmi_bridge u_dmi_bridge (
    .tck_i   (tck_i),
    .trstn_i (trstn_i),
    .scan_i  (u_scan_if.dreg),
    .sel_i   (dmi_sel),
    .tdo_o   (dmi_tdo),
    .dmi_o   (u_dmi_if.host)
  );

  dm_regfile u_dm_regfile (
    .tck_i      (tck_i),
    .trstn_i    (trstn_i),
    .dmi_i      (u_dmi_if.target),
    .dmactive_o (dmactive_o),
    .ndmreset_o (ndmreset_o)
  );

endmodule

// File: tb/tb_dtm_top.sv
`timescale 1ns/100ps

module tb_dtm_top;

  localparam int WAIT_LIMIT = 20;

  logic        tck_i = 1'b0;
  logic        trstn_i;
  logic        tms_i;
  logic        tdi_i;
  logic        tdo_o;
  logic        dmactive_o;
  logic        ndmreset_o;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] data0_val;
  logic [31:0] data1_val;

  dtm_top u_dtm_top (
    .tck_i      (tck_i),
    .trstn_i    (trstn_i),
    .tms_i      (tms_i),
    .tdi_i      (tdi_i),
    .tdo_o      (tdo_o),
    .dmactive_o (dmactive_o),
    .ndmreset_o (ndmreset_o)
  );

  always #50 tck_i = ~tck_i;

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  // returns the tdo bit shifted out at the next rising edge
  task automatic step(input logic tms, input logic tdi, output logic tdo);
    tms_i <= tms;
    tdi_i <= tdi;
    @(posedge tck_i);
    tdo = tdo_o;
  endtask

  task automatic tms_reset();
    logic unused;
    repeat (5) step(1'b1, 1'b0, unused);
  endtask

  task automatic goto_idle();
    logic unused;
    step(1'b0, 1'b0, unused);
  endtask

  // idle to idle with lsb first
  task automatic scan_ir(input logic [4:0] ins, output logic [4:0] cap);
    logic unused;
    logic bit_out;
    step(1'b1, 1'b0, unused);
    step(1'b1, 1'b0, unused);
    step(1'b0, 1'b0, unused);
    step(1'b0, 1'b0, unused);
    for (int i = 0; i < 5; i++)
    begin
      step(i == 4, ins[i], bit_out);
      cap[i] = bit_out;
    end
    step(1'b1, 1'b0, unused);
    step(1'b0, 1'b0, unused);
  endtask

  task automatic scan_dr(input int n, input logic [63:0] din, output logic [63:0] dout);
    logic unused;
    logic bit_out;
    dout = '0;
    step(1'b1, 1'b0, unused);
    step(1'b0, 1'b0, unused);
    step(1'b0, 1'b0, unused);
    for (int i = 0; i < n; i++)
    begin
      step(i == n - 1, din[i], bit_out);
      dout[i] = bit_out;
    end
    step(1'b1, 1'b0, unused);
    step(1'b0, 1'b0, unused);
  endtask

  task automatic load_ir(input logic [4:0] ins);
    logic [4:0] cap;
    scan_ir(ins, cap);
    check("ir capture", 64'(dtm_pkg::IR_CAPTURE), 64'(cap));
  endtask

  task automatic dmi_access(input dtm_pkg::dmi_op_e op, input dtm_pkg::dm_addr_e addr,
                            input logic [31:0] data, output dtm_pkg::dmi_req_t resp);
    dtm_pkg::dmi_req_t req;
    logic [63:0]       dout;
    req.addr = addr;
    req.data = data;
    req.op   = op;
    scan_dr($bits(dtm_pkg::dmi_req_t), 64'(req), dout);
    resp = dtm_pkg::dmi_req_t'(dout[40:0]);
  endtask

  function automatic logic pin_value(input string name);
    return (name == "ndmreset_o") ? ndmreset_o : dmactive_o;
  endfunction

  task automatic wait_pin(input string name, input logic level);
    int cycles;
    cycles = 0;
    while (pin_value(name) !== level && cycles < WAIT_LIMIT)
    begin
      @(posedge tck_i);
      cycles++;
    end
    if (pin_value(name) !== level)
    begin
      errors++;
      $display("timeout: %s did not reach %0b within %0d cycles", name, level, WAIT_LIMIT);
    end
  endtask

  task automatic bypass_shift(input logic [4:0] ins);
    logic [31:0] word;
    logic [63:0] dout;
    load_ir(ins);
    word = $urandom;
    scan_dr(33, 64'(word), dout);
    check("bypass", 64'({word, 1'b0}), 64'(dout[32:0]));
  endtask

  task automatic dmi_read_write();
    dtm_pkg::dmi_req_t resp;
    load_ir(dtm_pkg::DMI);
    dmi_access(dtm_pkg::WRITE, dtm_pkg::DMCONTROL, 32'h1, resp);
    wait_pin("dmactive_o", 1'b1);
    data0_val = $urandom;
    data1_val = $urandom;
    dmi_access(dtm_pkg::WRITE, dtm_pkg::DATA0, data0_val, resp);
    dmi_access(dtm_pkg::WRITE, dtm_pkg::DATA1, data1_val, resp);
    dmi_access(dtm_pkg::READ, dtm_pkg::DATA0, 32'h0, resp);
    // each read result arrives on the scan after it
    dmi_access(dtm_pkg::READ, dtm_pkg::DATA1, 32'h0, resp);
    check("data0", 64'(data0_val), 64'(resp.data));
    check("op", 64'(dtm_pkg::NOP), 64'(resp.op));
    dmi_access(dtm_pkg::READ, dtm_pkg::DMSTATUS, 32'h0, resp);
    check("data1", 64'(data1_val), 64'(resp.data));
    check("op", 64'(dtm_pkg::NOP), 64'(resp.op));
    dmi_access(dtm_pkg::NOP, dtm_pkg::DATA0, 32'h0, resp);
    check("dmstatus", 64'(dtm_pkg::DMSTATUS_VALUE), 64'(resp.data));
  endtask

  task automatic inactive_write_ignored();
    dtm_pkg::dmi_req_t resp;
    dmi_access(dtm_pkg::WRITE, dtm_pkg::DMCONTROL, 32'h3, resp);
    wait_pin("ndmreset_o", 1'b1);
    dmi_access(dtm_pkg::WRITE, dtm_pkg::DMCONTROL, 32'h0, resp);
    wait_pin("dmactive_o", 1'b0);
    dmi_access(dtm_pkg::WRITE, dtm_pkg::DATA0, ~data0_val, resp);
    dmi_access(dtm_pkg::READ, dtm_pkg::DATA0, 32'h0, resp);
    dmi_access(dtm_pkg::NOP, dtm_pkg::DATA0, 32'h0, resp);
    check("data0 while inactive", 64'(data0_val), 64'(resp.data));
  endtask

  // leave a dmi scan halfway through shift-dr
  task automatic reset_from_shift();
    logic        unused;
    logic [63:0] dout;
    step(1'b1, 1'b0, unused);
    step(1'b0, 1'b0, unused);
    step(1'b0, 1'b0, unused);
    repeat (3) step(1'b0, 1'b0, unused);
    tms_reset();
    goto_idle();
    scan_dr(32, 64'h0, dout);
    check("idcode after tms reset", 64'(dtm_pkg::IDCODE_VALUE), 64'(dout[31:0]));
  endtask

  initial
  begin
    logic [63:0] dout;
    trstn_i = 1'b0;
    tms_i   = 1'b1;
    tdi_i   = 1'b0;
    void'($urandom(32'h9b8e_dd2c));
    repeat (2) @(posedge tck_i);
    trstn_i <= 1'b1;
    goto_idle();
    scan_dr(32, 64'h0, dout);
    check("idcode", 64'(dtm_pkg::IDCODE_VALUE), 64'(dout[31:0]));
    load_ir(dtm_pkg::DTMCS);
    scan_dr(32, 64'h0, dout);
    // abits 7 in [9:4] and version 1 in [3:0]
    check("dtmcs", 64'(32'h0000_0071), 64'(dout[31:0]));
    bypass_shift(dtm_pkg::BYPASS);
    bypass_shift(5'h00);
    dmi_read_write();
    inactive_write_ignored();
    reset_from_shift();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: src.f
src/dtm_pkg.sv
src/dtm_scan_if.sv
src/dmi_if.sv
src/tap_controller.sv
src/scan_dr.sv
src/dmi_bridge.sv
src/dm_regfile.sv
src/dtm_top.sv
tb/tb_dtm_top.sv

// File: Makefile
TOP := tb_dtm_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)

# the exit status follows the search for the pass message
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
